// File: flist.f
+incdir+design
design/timer_bus_pkg.sv
design/timer_core_pkg.sv
design/timer_bus_decode.sv
design/timer_channel.sv
design/timer_read_mux.sv
design/timer_block.sv
verif/tb_clk_gen.sv
verif/timer_block_tb.sv

// File: run.sh
#!/bin/sh
# build the timer block testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module timer_block_tb \
    -Mdir obj_dir \
    -o timer_block_tb_sim

./obj_dir/timer_block_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: verif/timer_block_tb.sv
// timer block testbench: stimulus table, bus tasks, interrupt timing checks, watchdog, report
`include "timer_defines.svh"

module timer_block_tb
    import timer_bus_pkg::*;
();

    // table operations
    localparam int OP_WR   = 0;
    localparam int OP_RD   = 1;
    localparam int OP_WAIT = 2;
    localparam int OP_INT  = 3;

    localparam int ACK_LIMIT  = 4;
    localparam int ROW_CYCLES = 20;
    localparam int RST_CYCLES = 16;
    localparam int MARGIN     = 200;

    logic                   clk;
    logic                   rstn;
    bus_addr_t              wb_adr;
    logic                   wb_we;
    bus_data_t              wb_dat;
    logic                   wb_cyc;
    logic                   wb_stb;
    bus_data_t              wb_rdat;
    logic                   wb_ack;
    logic [`TMR_NUM_CH-1:0] timer_int;

    // stimulus table, one entry per row in each queue
    int        op_q  [$];
    bus_addr_t adr_q [$];
    bus_data_t dat_q [$];
    bus_data_t exp_q [$];

    int     val_errors;
    int     ack_errors;
    integer seed;
    bit     table_ready;
    int     limit_cycles;
    int     row;

    tb_clk_gen u_clk_gen (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    timer_block dut (
        .i_clk       (clk),
        .i_rstn      (rstn),
        .i_wb_adr    (wb_adr),
        .i_wb_we     (wb_we),
        .i_wb_dat    (wb_dat),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .o_wb_dat    (wb_rdat),
        .o_wb_ack    (wb_ack),
        .o_timer_int (timer_int)
    );

    // ==============================
    // table helpers
    // ==============================
    task automatic add_row(input int op, input bus_addr_t adr, input bus_data_t dat,
                           input bus_data_t exp);
        op_q.push_back(op);
        adr_q.push_back(adr);
        dat_q.push_back(dat);
        exp_q.push_back(exp);
    endtask

    // cycles the table may take, for the watchdog
    function automatic int table_cycles();
        int sum;
        int i;
        sum = 0;
        for (i = 0; i < op_q.size(); i++)
        begin
            sum += ROW_CYCLES;
            if (op_q[i] == OP_WAIT || op_q[i] == OP_INT)
                sum += int'(dat_q[i]);
        end
        return sum;
    endfunction

    // ==============================
    // bus and interrupt tasks
    // ==============================
    task automatic bus_write(input bus_addr_t adr, input bus_data_t dat);
        @(posedge clk);
        wb_adr <= adr;
        wb_dat <= dat;
        wb_we  <= 1'b1;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        // write ack comes in the request cycle
        @(negedge clk);
        if (wb_ack !== 1'b1)
        begin
            $display("write to %h got no ack in its request cycle", adr);
            ack_errors++;
        end
        // register takes the data on this edge
        @(posedge clk);
        wb_we  <= 1'b0;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t adr, input bus_data_t exp);
        int waited;
        bit got_ack;
        waited  = 0;
        got_ack = 1'b0;
        @(posedge clk);
        wb_adr <= adr;
        wb_we  <= 1'b0;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        @(negedge clk);
        while (!got_ack && waited < ACK_LIMIT)
        begin
            @(posedge clk);
            @(negedge clk);
            waited++;
            if (wb_ack === 1'b1)
                got_ack = 1'b1;
        end
        if (!got_ack)
        begin
            $display("read of %h got no ack within %0d cycles", adr, ACK_LIMIT);
            ack_errors++;
        end
        else if (wb_rdat !== exp)
        begin
            $display("FAILED o_wb_dat at %h: expected %h, got %h", adr, exp, wb_rdat);
            val_errors++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // bits must equal exp after exactly n edges and differ before
    task automatic expect_int(input int n, input logic [`TMR_NUM_CH-1:0] exp);
        int k;
        if (n == 0)
        begin
            @(negedge clk);
            if (timer_int !== exp)
            begin
                $display("FAILED o_timer_int: expected %h, got %h", exp, timer_int);
                val_errors++;
            end
        end
        for (k = 1; k <= n; k++)
        begin
            @(posedge clk);
            @(negedge clk);
            if (k < n && timer_int === exp)
            begin
                $display("interrupt bits %h arrived %0d cycles early", exp, n - k);
                val_errors++;
            end
            else if (k == n && timer_int !== exp)
            begin
                $display("FAILED o_timer_int: expected %h, got %h", exp, timer_int);
                val_errors++;
            end
        end
    endtask

    // ==============================
    // stimulus table
    // ==============================
    task automatic build_table();
        bus_data_t rnd;
        int        ch;
        // reset state of every channel
        for (ch = 0; ch < `TMR_NUM_CH; ch++)
        begin
            add_row(OP_RD, bus_addr_t'(ch * 256),     32'h0, 32'h0);
            add_row(OP_RD, bus_addr_t'(ch * 256 + 4), 32'h0, 32'hFFFF);
            add_row(OP_RD, bus_addr_t'(ch * 256 + 8), 32'h0, 32'h0);
        end
        add_row(OP_INT, 32'h0, 32'd0, 32'h0);
        // load readback, top load bit set so the count stays far from zero
        rnd = $random(seed);
        rnd = rnd | 32'h8000;
        add_row(OP_WR, 32'h000, rnd, 32'h0);
        add_row(OP_RD, 32'h000, 32'h0, rnd & 32'hFFFF);
        // only enable, periodic and prescale stick
        add_row(OP_WR, 32'h008, 32'hFF, 32'h0);
        add_row(OP_RD, 32'h008, 32'h0, 32'hCC);
        add_row(OP_WR, 32'h008, 32'h0, 32'h0);
        // clear address, window gap, missing channel
        add_row(OP_RD, 32'h00C, 32'h0, 32'h6677_8899);
        add_row(OP_RD, 32'h010, 32'h0, 32'h6677_8899);
        add_row(OP_RD, 32'h300, 32'h0, 32'h6677_8899);
        add_row(OP_RD, 32'h100, 32'h0, 32'h0);
        // ch0 one-shot, prescale 0, load 10
        add_row(OP_WR,  32'h008, 32'h80,  32'h0);
        add_row(OP_WR,  32'h000, 32'd10,  32'h0);
        add_row(OP_INT, 32'h0,   32'd11,  32'h1);
        // wrapped to all ones, one more step before the read samples
        add_row(OP_RD,  32'h004, 32'h0,   32'hFFFE);
        add_row(OP_RD,  32'h104, 32'h0,   32'hFFFF);
        add_row(OP_RD,  32'h200, 32'h0,   32'h0);
        add_row(OP_WR,  32'h008, 32'h0,   32'h0);
        add_row(OP_WR,  32'h00C, 32'h0,   32'h0);
        add_row(OP_INT, 32'h0,   32'd0,   32'h0);
        // ch2 prescale 1, load 3
        add_row(OP_WR,  32'h208, 32'h84,  32'h0);
        add_row(OP_WR,  32'h200, 32'd3,   32'h0);
        add_row(OP_INT, 32'h0,   32'd49,  32'h4);
        add_row(OP_WR,  32'h208, 32'h0,   32'h0);
        add_row(OP_WR,  32'h20C, 32'h0,   32'h0);
        add_row(OP_INT, 32'h0,   32'd0,   32'h0);
        add_row(OP_RD,  32'h000, 32'h0,   32'd10);
        add_row(OP_RD,  32'h100, 32'h0,   32'h0);
        // ch0 prescale 2, load 2
        add_row(OP_WR,  32'h008, 32'h88,  32'h0);
        add_row(OP_WR,  32'h000, 32'd2,   32'h0);
        add_row(OP_INT, 32'h0,   32'd513, 32'h1);
        add_row(OP_WR,  32'h008, 32'h0,   32'h0);
        add_row(OP_WR,  32'h00C, 32'h0,   32'h0);
        add_row(OP_INT, 32'h0,   32'd0,   32'h0);
        // ch1 prescale 3 holds the loaded value
        add_row(OP_WR,   32'h108, 32'h8C,  32'h0);
        add_row(OP_WR,   32'h100, 32'd7,   32'h0);
        add_row(OP_WAIT, 32'h0,   32'd300, 32'h0);
        add_row(OP_INT,  32'h0,   32'd0,   32'h0);
        add_row(OP_RD,   32'h104, 32'h0,   32'd7);
        add_row(OP_RD,   32'h108, 32'h0,   32'h8C);
        // ch1 periodic, prescale 0, load 5
        add_row(OP_WR,  32'h108, 32'hC0,  32'h0);
        add_row(OP_WR,  32'h100, 32'd5,   32'h0);
        add_row(OP_INT, 32'h0,   32'd6,   32'h2);
        add_row(OP_WR,  32'h10C, 32'h0,   32'h0);
        add_row(OP_INT, 32'h0,   32'd0,   32'h0);
        // next zero lands four edges after the clear
        add_row(OP_INT, 32'h0,   32'd4,   32'h2);
        add_row(OP_WR,  32'h108, 32'h0,   32'h0);
        add_row(OP_WR,  32'h10C, 32'h0,   32'h0);
        add_row(OP_INT, 32'h0,   32'd0,   32'h0);
        add_row(OP_RD,  32'h208, 32'h0,   32'h0);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial
    begin
        wb_adr      = '0;
        wb_we       = 1'b0;
        wb_dat      = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        val_errors  = 0;
        ack_errors  = 0;
        seed        = 63;
        build_table();
        limit_cycles = table_cycles() + RST_CYCLES + MARGIN;
        table_ready  = 1'b1;
        wait (rstn === 1'b1);
        @(negedge clk);
        if (wb_ack !== 1'b0)
        begin
            $display("FAILED o_wb_ack after reset: expected 0, got %h", wb_ack);
            val_errors++;
        end
        for (row = 0; row < op_q.size(); row++)
        begin
            case (op_q[row])
                OP_WR:   bus_write(adr_q[row], dat_q[row]);
                OP_RD:   bus_read(adr_q[row], exp_q[row]);
                OP_WAIT: repeat (int'(dat_q[row])) @(posedge clk);
                default: expect_int(int'(dat_q[row]), exp_q[row][`TMR_NUM_CH-1:0]);
            endcase
        end
        repeat (2) @(posedge clk);
        $display("value errors: %0d, ack errors: %0d", val_errors, ack_errors);
        if (val_errors == 0 && ack_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog, limit set from the table length
    initial
    begin
        wait (table_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", limit_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
// testbench clock generator and synchronous active-low reset
module tb_clk_gen
(
    output logic o_clk,
    output logic o_rstn
);

    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 16;

    // free running clock, period 10
    initial
    begin
        o_clk = 1'b0;
        forever
            #HALF_PERIOD o_clk = ~o_clk;
    end

    // reset low for the first 16 rising edges
    initial
    begin
        o_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rstn <= 1'b1;
    end

endmodule

// File: design/timer_block.sv
// top level: bus decoder, generate loop of timer channels, read multiplexer
`include "timer_defines.svh"

module timer_block
    import timer_bus_pkg::*;
    import timer_core_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  bus_addr_t              i_wb_adr,
    input  logic                   i_wb_we,
    input  bus_data_t              i_wb_dat,
    // cycle qualifier, not needed, stb alone frames a transfer
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    output bus_data_t              o_wb_dat,
    output logic                   o_wb_ack,
    output logic [`TMR_NUM_CH-1:0] o_timer_int
);

    logic                   rd_start;
    logic [`TMR_NUM_CH-1:0] load_we;
    logic [`TMR_NUM_CH-1:0] ctrl_we;
    logic [`TMR_NUM_CH-1:0] clr_we;
    bus_data_t              wdata;
    load_t                  ch_load      [`TMR_NUM_CH];
    count_vis_t             ch_count_vis [`TMR_NUM_CH];
    logic [`TMR_NUM_CH-1:0] ch_enable;
    logic [`TMR_NUM_CH-1:0] ch_periodic;
    prescale_e              ch_prescale  [`TMR_NUM_CH];

    // ==============================
    // bus side
    // ==============================
    timer_bus_decode u_decode (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_wb_adr   (i_wb_adr),
        .i_wb_we    (i_wb_we),
        .i_wb_stb   (i_wb_stb),
        .i_wb_dat   (i_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_rd_start (rd_start),
        .o_load_we  (load_we),
        .o_ctrl_we  (ctrl_we),
        .o_clr_we   (clr_we),
        .o_wdata    (wdata)
    );

    // ==============================
    // timer channels
    // ==============================
    for (genvar ch = 0; ch < `TMR_NUM_CH; ch++)
    begin : g_ch
        timer_channel u_channel (
            .i_clk       (i_clk),
            .i_rstn      (i_rstn),
            .i_load_we   (load_we[ch]),
            .i_ctrl_we   (ctrl_we[ch]),
            .i_clr_we    (clr_we[ch]),
            .i_wdata     (wdata),
            .o_load      (ch_load[ch]),
            .o_count_vis (ch_count_vis[ch]),
            .o_enable    (ch_enable[ch]),
            .o_periodic  (ch_periodic[ch]),
            .o_prescale  (ch_prescale[ch]),
            .o_int       (o_timer_int[ch])
        );
    end

    // read data back to the bus
    timer_read_mux u_read_mux (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_rd_start  (rd_start),
        .i_wb_adr    (i_wb_adr),
        .i_load      (ch_load),
        .i_count_vis (ch_count_vis),
        .i_enable    (ch_enable),
        .i_periodic  (ch_periodic),
        .i_prescale  (ch_prescale),
        .o_rdata     (o_wb_dat)
    );

endmodule

// File: design/timer_read_mux.sv
// registered read data, selected from all channels by the bus address
`include "timer_defines.svh"

module timer_read_mux
    import timer_bus_pkg::*;
    import timer_core_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  logic                   i_rd_start,
    input  bus_addr_t              i_wb_adr,
    input  load_t                  i_load      [`TMR_NUM_CH],
    input  count_vis_t             i_count_vis [`TMR_NUM_CH],
    input  logic [`TMR_NUM_CH-1:0] i_enable,
    input  logic [`TMR_NUM_CH-1:0] i_periodic,
    input  prescale_e              i_prescale  [`TMR_NUM_CH],
    output bus_data_t              o_rdata
);

    logic [`TMR_DEC_W-1:0] dec_adr;
    logic [`TMR_DEC_W-1:0] ch_base;
    ch_sel_t               ch_idx;
    reg_ofs_e              reg_ofs;
    logic                  map_hit;
    bus_data_t             rd_next;

    // same split as the write side
    assign dec_adr = i_wb_adr[`TMR_DEC_W-1:0];
    assign ch_idx  = ch_sel_t'(i_wb_adr[9:8]);
    assign reg_ofs = reg_ofs_e'(i_wb_adr[3:0]);
    assign ch_base = `TMR_DEC_W'(ch_idx) * `TMR_DEC_W'(`TMR_CH_STRIDE);
    assign map_hit = (ch_idx < ch_sel_t'(`TMR_NUM_CH)) &&
                     (dec_adr == ch_base + `TMR_DEC_W'(reg_ofs));

    always_comb
    begin
        rd_next = `TMR_UNMAPPED_RD;
        if (map_hit)
        begin
            case (reg_ofs)
                OFS_LOAD:  rd_next = bus_data_t'(i_load[ch_idx]);
                OFS_VALUE: rd_next = bus_data_t'(i_count_vis[ch_idx]);
                OFS_CTRL:
                begin
                    // unused control bits read as zero
                    rd_next = '0;
                    rd_next[`TMR_CTRL_EN_BIT]     = i_enable[ch_idx];
                    rd_next[`TMR_CTRL_PER_BIT]    = i_periodic[ch_idx];
                    rd_next[`TMR_CTRL_PS_LSB +: 2] = i_prescale[ch_idx];
                end
                // clear address is write only
                default:   rd_next = `TMR_UNMAPPED_RD;
            endcase
        end
    end

    // captured at read start, valid with the ack
    always_ff @(posedge i_clk)
    begin
        if (!i_rstn)
            o_rdata <= '0;
        else if (i_rd_start)
            o_rdata <= rd_next;
    end

endmodule

// File: design/timer_channel.sv
// one timer channel: load, control, 24-bit down-counter, sticky interrupt flag
`include "timer_defines.svh"

module timer_channel
    import timer_bus_pkg::*;
    import timer_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rstn,
    input  logic       i_load_we,
    input  logic       i_ctrl_we,
    input  logic       i_clr_we,
    input  bus_data_t  i_wdata,
    output load_t      o_load,
    output count_vis_t o_count_vis,
    output logic       o_enable,
    output logic       o_periodic,
    output prescale_e  o_prescale,
    output logic       o_int
);

    // step sizes and the fraction masks applied before a step
    localparam count_t STEP_256 = count_t'(1) << `TMR_FRAC_W;
    localparam count_t STEP_16  = count_t'(16);
    localparam count_t MASK_256 = ~(STEP_256 - count_t'(1));
    localparam count_t MASK_16  = ~(STEP_16 - count_t'(1));

    load_t     load_r;
    count_t    count_r;
    count_t    count_next;
    logic      enable_r;
    logic      periodic_r;
    prescale_e prescale_r;
    logic      int_r;
    logic      count_zero;

    assign count_zero = (count_r == '0);

    // ==============================
    // counter
    // ==============================
    always_comb
    begin
        count_next = count_r;
        if (i_load_we)
            count_next = {i_wdata[`TMR_LOAD_W-1:0], `TMR_FRAC_W'(0)};
        else if (enable_r)
        begin
            // zero reached, reload or wrap to all ones
            if (count_zero)
                count_next = periodic_r ? {load_r, `TMR_FRAC_W'(0)} : `TMR_COUNT_RST;
            else
            begin
                case (prescale_r)
                    PS_DIV256: count_next = (count_r & MASK_256) - STEP_256;
                    PS_DIV16:  count_next = (count_r & MASK_16) - STEP_16;
                    PS_DIV1:   count_next = count_r - count_t'(1);
                    // hold
                    default:   count_next = count_r;
                endcase
            end
        end
    end

    // ==============================
    // registers
    // ==============================
    always_ff @(posedge i_clk)
    begin
        if (!i_rstn)
        begin
            load_r     <= '0;
            count_r    <= `TMR_COUNT_RST;
            enable_r   <= 1'b0;
            periodic_r <= 1'b0;
            prescale_r <= PS_DIV256;
            int_r      <= 1'b0;
        end
        else
        begin
            count_r <= count_next;
            if (i_load_we)
                load_r <= i_wdata[`TMR_LOAD_W-1:0];
            if (i_ctrl_we)
            begin
                enable_r   <= i_wdata[`TMR_CTRL_EN_BIT];
                periodic_r <= i_wdata[`TMR_CTRL_PER_BIT];
                prescale_r <= prescale_e'(i_wdata[`TMR_CTRL_PS_LSB +: 2]);
            end
            // clear beats a same-cycle set
            if (i_clr_we)
                int_r <= 1'b0;
            else if (count_zero)
                int_r <= 1'b1;
        end
    end

    assign o_load      = load_r;
    assign o_count_vis = count_r[`TMR_COUNT_W-1:`TMR_FRAC_W];
    assign o_enable    = enable_r;
    assign o_periodic  = periodic_r;
    assign o_prescale  = prescale_r;
    assign o_int       = int_r;

    // flag is sticky until software clears it
    a_int_fall: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $fell(int_r) |-> $past(i_clr_we));

    // disabled counter only moves on a load
    a_count_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !enable_r && !i_load_we |=> $stable(count_r));

endmodule

// File: design/timer_bus_decode.sv
// bus strobe logic, ack generation and per-channel register write strobes
`include "timer_defines.svh"

module timer_bus_decode
    import timer_bus_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  bus_addr_t              i_wb_adr,
    input  logic                   i_wb_we,
    input  logic                   i_wb_stb,
    input  bus_data_t              i_wb_dat,
    output logic                   o_wb_ack,
    output logic                   o_rd_start,
    output logic [`TMR_NUM_CH-1:0] o_load_we,
    output logic [`TMR_NUM_CH-1:0] o_ctrl_we,
    output logic [`TMR_NUM_CH-1:0] o_clr_we,
    output bus_data_t              o_wdata
);

    logic                  rd_pend;
    logic                  start_write;
    logic [`TMR_DEC_W-1:0] dec_adr;
    logic [`TMR_DEC_W-1:0] ch_base;
    ch_sel_t               ch_idx;
    reg_ofs_e              reg_ofs;
    logic                  map_hit;

    // ==============================
    // handshake
    // ==============================

    // a write waits while a read ack is due
    assign start_write = i_wb_stb && i_wb_we && !rd_pend;
    assign o_rd_start  = i_wb_stb && !i_wb_we && !o_wb_ack;

    // write ack same cycle, read ack one cycle after start
    assign o_wb_ack = i_wb_stb && (start_write || rd_pend);

    always_ff @(posedge i_clk)
    begin
        if (!i_rstn)
            rd_pend <= 1'b0;
        else
            rd_pend <= o_rd_start;
    end

    // ==============================
    // address decode
    // ==============================
    assign dec_adr = i_wb_adr[`TMR_DEC_W-1:0];
    assign ch_idx  = ch_sel_t'(i_wb_adr[9:8]);
    assign reg_ofs = reg_ofs_e'(i_wb_adr[3:0]);
    assign ch_base = `TMR_DEC_W'(ch_idx) * `TMR_DEC_W'(`TMR_CH_STRIDE);

    // exact match on base plus offset, so gaps in the window miss
    assign map_hit = (ch_idx < ch_sel_t'(`TMR_NUM_CH)) &&
                     (dec_adr == ch_base + `TMR_DEC_W'(reg_ofs));

    always_comb
    begin
        o_load_we = '0;
        o_ctrl_we = '0;
        o_clr_we  = '0;
        if (start_write && map_hit)
        begin
            case (reg_ofs)
                OFS_LOAD: o_load_we[ch_idx] = 1'b1;
                OFS_CTRL: o_ctrl_we[ch_idx] = 1'b1;
                OFS_CLR:  o_clr_we[ch_idx]  = 1'b1;
                // value register is read only
                default:  ;
            endcase
        end
    end

    assign o_wdata = i_wb_dat;

    // at most one register written per bus cycle
    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $onehot0({o_load_we, o_ctrl_we, o_clr_we}));

    // after a read ack the master drops stb or moves to a new request
    a_rd_ack_end: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_wb_ack && !i_wb_we |=> !i_wb_stb || i_wb_we || !$stable(i_wb_adr));

endmodule

// File: design/timer_core_pkg.sv
// counter types: load word, count word, visible count and prescale enum
`include "timer_defines.svh"

package timer_core_pkg;

    // software load value
    typedef logic [`TMR_LOAD_W-1:0] load_t;

    // internal down-counter, load value sits above the fraction bits
    typedef logic [`TMR_COUNT_W-1:0] count_t;

    // upper count bits as seen on a value read
    typedef logic [`TMR_COUNT_W-`TMR_FRAC_W-1:0] count_vis_t;

    // step size per clock
    typedef enum logic [1:0]
    {
        PS_DIV256 = 2'd0,
        PS_DIV16  = 2'd1,
        PS_DIV1   = 2'd2,
        // counter frozen
        PS_HOLD   = 2'd3
    } prescale_e;

endpackage

// File: design/timer_bus_pkg.sv
// register port types: address, data word, channel index and register offset enum
`include "timer_defines.svh"

package timer_bus_pkg;

    // full bus address and data word
    typedef logic [`TMR_ADDR_W-1:0] bus_addr_t;
    typedef logic [`TMR_DATA_W-1:0] bus_data_t;

    // channel index, address bits 9:8
    typedef logic [1:0] ch_sel_t;

    // register offset within one channel window
    typedef enum logic [3:0]
    {
        OFS_LOAD  = `TMR_OFS_LOAD,
        OFS_VALUE = `TMR_OFS_VALUE,
        OFS_CTRL  = `TMR_OFS_CTRL,
        // write only, reads return the unmapped word
        OFS_CLR   = `TMR_OFS_CLR
    } reg_ofs_e;

endpackage

// File: design/timer_defines.svh
// timer block macros: channel count, widths, register map, reset values, unmapped read word
`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// channel count and bus widths
`define TMR_NUM_CH      3
`define TMR_ADDR_W      32
`define TMR_DATA_W      32
// address bits that take part in decoding
`define TMR_DEC_W       12

// counter widths, low fraction bits are hidden from software
`define TMR_LOAD_W      16
`define TMR_COUNT_W     24
`define TMR_FRAC_W      8

// register map, one 256 byte window per channel
`define TMR_CH_STRIDE   'h100
`define TMR_OFS_LOAD    4'h0
`define TMR_OFS_VALUE   4'h4
`define TMR_OFS_CTRL    4'h8
`define TMR_OFS_CLR     4'hC

// control byte layout
`define TMR_CTRL_EN_BIT   7
`define TMR_CTRL_PER_BIT  6
`define TMR_CTRL_PS_LSB   2

`define TMR_COUNT_RST     24'hFF_FFFF
`define TMR_UNMAPPED_RD   32'h6677_8899

`endif
